// File: verif/decode_input.txt
# instr unit isAlu isLoad isStore memSize isBranch isDecBranch cond rd rs1 rs2 writesRd imm
# All hex; unit 0 alu 1 fpu 2 mem 3 branch 4 illegal; memSize 0 byte 1 half 2 word
00062084 0 1 0 0 2 0 0 0 01 02 03 1 00000003
FFFE4185 0 1 0 0 2 0 0 7 03 04 1f 1 ffffffff
00045006 0 1 0 0 2 0 0 0 00 05 02 0 00000002
00001386 0 1 0 0 0 0 0 0 07 01 00 1 00000000
80009407 0 1 0 0 0 0 0 4 08 09 00 1 ffffc000
7FFE3108 0 1 0 0 2 0 0 3 02 03 1f 1 00003fff
00205209 0 1 0 0 0 0 0 0 04 05 10 1 00000010
0002628A 0 1 0 0 1 0 0 0 05 06 01 1 00000001
0000730B 0 1 0 0 0 0 0 0 06 07 00 1 00000000
003FFF8C 0 1 0 0 2 0 0 0 1f 1f 1f 1 0000001f
FFFC008D 0 1 0 0 2 0 0 7 01 00 1e 1 fffffffe
0200110E 0 1 0 0 0 0 0 0 02 01 00 1 00000100
000A218F 0 1 0 0 1 0 0 0 03 02 05 1 00000005
00003210 0 1 0 0 0 0 0 0 04 03 00 1 00000000
00000011 0 1 0 0 0 0 0 0 00 00 00 0 00000000
00000012 0 1 0 0 0 0 0 0 00 00 00 0 00000000
FFF84F13 0 1 0 0 0 0 0 7 1e 04 1c 1 fffffffc
00080F14 0 1 0 0 0 0 0 0 1e 00 04 1 00000004
200241A0 0 1 0 0 1 0 0 1 03 04 01 1 00001001
200441A0 1 0 0 0 2 0 0 1 03 04 02 1 00001002
000241A0 1 0 0 0 1 0 0 0 03 04 01 1 00000001
020062A0 0 1 0 0 0 0 0 0 05 06 00 1 00000100
C1001120 1 0 0 0 0 0 0 6 02 01 00 1 ffffe080
008083B0 2 0 1 0 0 0 0 0 07 08 00 1 00000040
FFC220B0 2 0 1 0 1 0 0 7 01 02 01 1 ffffffe1
004441B1 2 0 0 1 2 0 0 0 03 04 02 0 00000022
00065031 2 0 0 1 2 0 0 0 00 05 03 0 00000003
A0000040 3 0 0 0 0 1 0 5 00 00 00 0 ffffd000
40200040 3 0 0 0 0 1 0 2 00 00 10 0 00002010
7FF004C1 0 1 0 0 0 1 1 3 09 00 18 1 00003ff8
00000000 4 0 0 0 0 0 0 0 00 00 00 0 00000000
FFFFFFFF 4 0 0 0 2 0 0 7 1f 1f 1f 0 ffffffff
00000015 4 0 0 0 0 0 0 0 00 00 00 0 00000000

// File: sim.f
rtl/isaPkg.sv
rtl/decodePkg.sv
rtl/decodeAlu.sv
rtl/decodeMem.sv
rtl/decodeBranch.sv
rtl/decodeOperands.sv
rtl/decodeStage.sv
verif/decodeStage_sva.sv
verif/decodeChecker.sv
verif/decodeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decodeTb -f sim.f

status=0
out=$(./obj_dir/VdecodeTb 2>&1) || status=$?
echo "$out"
[ "$status" -eq 0 ]
echo "$out" | grep -qx "SIMULATION PASSED"

// File: verif/decodeTb.sv
// Decode stage testbench
`timescale 1ns/1ns

module decodeTb;

	localparam int immWidth = 32;
	localparam int resetCycles = 16;
	localparam int cyclesPerRecord = 20;

	logic clk = 1'b0;
	logic rstN = 1'b0;
	logic instrValid = 1'b0;
	logic [isaPkg::instrWidth-1:0] instr = '0;
	logic outReady = 1'b0;
	logic instrReady;
	logic outValid;
	decodePkg::unit_t unit;
	decodePkg::memSize_t memSize;
	logic isAlu;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic isDecBranch;
	logic writesRd;
	logic [decodePkg::condWidth-1:0] cond;
	logic [decodePkg::regIdxWidth-1:0] rd;
	logic [decodePkg::regIdxWidth-1:0] rs1;
	logic [decodePkg::regIdxWidth-1:0] rs2;
	logic [immWidth-1:0] imm;

	int mismatchCount;
	int extraCount;
	int seenCount;

	// Instruction words from the file wait here and their expected records wait in the checker
	logic [isaPkg::instrWidth-1:0] vecInstr [$];
	int vecCount = 0;
	int badLines = 0;
	int sendIdx = 0;
	logic loaded = 1'b0;
	logic [31:0] lfsrState = 32'ha721_1887;

	decodeStage #(.immWidth(immWidth)) dut_i
	(
		.clk (clk), .rstN (rstN), .instrValid (instrValid), .instrReady (instrReady),
		.instr (instr), .outReady (outReady), .outValid (outValid), .unit (unit),
		.isAlu (isAlu), .isLoad (isLoad), .isStore (isStore), .memSize (memSize),
		.isBranch (isBranch), .isDecBranch (isDecBranch), .cond (cond), .rd (rd),
		.rs1 (rs1), .rs2 (rs2), .writesRd (writesRd), .imm (imm)
	);

	decodeChecker #(.immWidth(immWidth)) outCheck
	(
		.clk (clk), .rstN (rstN), .outValid (outValid), .outReady (outReady), .unit (unit),
		.isAlu (isAlu), .isLoad (isLoad), .isStore (isStore), .memSize (memSize),
		.isBranch (isBranch), .isDecBranch (isDecBranch), .cond (cond), .rd (rd),
		.rs1 (rs1), .rs2 (rs2), .writesRd (writesRd), .imm (imm),
		.mismatchCount (mismatchCount), .extraCount (extraCount), .seenCount (seenCount)
	);

	// =========================================================================
	// Random source and file reader
	// =========================================================================

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per returned bit
	function automatic logic [7:0] randomBits(input int count);
		logic [7:0] bits;
		int k;
		bits = '0;
		for (k = 0; k < count; k++)
		begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[6:0], lfsrState[0]};
		end
		return bits;
	endfunction

	task automatic loadVectors();
		int fd;
		int got;
		string line;
		logic [31:0] eInstr;
		logic [31:0] eImm;
		logic [2:0] eUnit;
		logic [2:0] eCond;
		logic [1:0] eSize;
		logic [4:0] eRd;
		logic [4:0] eRs1;
		logic [4:0] eRs2;
		logic eAlu;
		logic eLoad;
		logic eStore;
		logic eBranch;
		logic eDec;
		logic eWrites;
		fd = $fopen("verif/decode_input.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			// Comment and blank lines hold no vector
			if (line.len() > 1 && line.getc(0) != "#")
			begin
				got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", eInstr,
					eUnit, eAlu, eLoad, eStore, eSize, eBranch, eDec, eCond, eRd, eRs1, eRs2,
					eWrites, eImm);
				if (got == 14)
				begin
					vecInstr.push_back(eInstr);
					outCheck.addExpected(eUnit, eAlu, eLoad, eStore, eSize, eBranch, eDec,
						eCond, eRd, eRs1, eRs2, eWrites, immWidth'($signed(eImm)));
				end
				else
				begin
					$display("Malformed line in the stimulus file: %s", line);
					badLines++;
				end
			end
		end
		$fclose(fd);
		vecCount = vecInstr.size();
	endtask

	task automatic printCounts();
		$display("Errors: %0d mismatched fields, %0d extra records, %0d missing, %0d bad lines",
			mismatchCount, extraCount, vecCount - seenCount, badLines);
	endtask

	// =========================================================================
	// Clock, stimulus and verdict
	// =========================================================================

	initial
	begin
		forever #50 clk = ~clk;
	end

	// Input gaps one cycle in four, output stalls one cycle in four
	always @(posedge clk)
	begin
		if (!rstN)
		begin
			instrValid <= 1'b0;
			outReady   <= 1'b0;
		end
		else
		begin
			outReady <= (randomBits(2) != 8'd0);
			// The next word may go out only once the current offer is taken
			if (!instrValid || instrReady)
			begin
				if (sendIdx < vecCount && randomBits(2) != 8'd0)
				begin
					instrValid <= 1'b1;
					instr      <= vecInstr[sendIdx];
					sendIdx++;
				end
				else
					instrValid <= 1'b0;
			end
		end
	end

	initial
	begin
		loadVectors();
		loaded = 1'b1;
		if (vecCount == 0)
		begin
			$display("No stimulus could be read from verif/decode_input.txt");
			printCounts();
			$display("SIMULATION FAILED");
			$finish;
		end
		else
		begin
			repeat (resetCycles) @(posedge clk);
			rstN <= 1'b1;
			wait (seenCount == vecCount);
			// A few more cycles so that a stray extra record would be caught
			repeat (4) @(posedge clk);
			printCounts();
			if (mismatchCount == 0 && extraCount == 0 && badLines == 0)
				$display("SIMULATION PASSED");
			else
				$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Watchdog scaled to the number of records
	initial
	begin
		wait (loaded && vecCount > 0);
		repeat (vecCount * cyclesPerRecord + resetCycles) @(posedge clk);
		$display("Timeout: only %0d of %0d records came out in time", seenCount, vecCount);
		printCounts();
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: verif/decodeChecker.sv
// Decoded record checker
`timescale 1ns/1ns

module decodeChecker
#(
	parameter int immWidth = 32
)
(
	input  logic                               clk,
	input  logic                               rstN,
	input  logic                               outValid,
	input  logic                               outReady,
	input  logic [decodePkg::unitWidth-1:0]    unit,
	input  logic                               isAlu,
	input  logic                               isLoad,
	input  logic                               isStore,
	input  logic [decodePkg::memSizeWidth-1:0] memSize,
	input  logic                               isBranch,
	input  logic                               isDecBranch,
	input  logic [decodePkg::condWidth-1:0]    cond,
	input  logic [decodePkg::regIdxWidth-1:0]  rd,
	input  logic [decodePkg::regIdxWidth-1:0]  rs1,
	input  logic [decodePkg::regIdxWidth-1:0]  rs2,
	input  logic                               writesRd,
	input  logic [immWidth-1:0]                imm,
	output int                                 mismatchCount,
	output int                                 extraCount,
	output int                                 seenCount
);

	typedef struct packed {
		logic [decodePkg::unitWidth-1:0]    unit;
		logic                               isAlu;
		logic                               isLoad;
		logic                               isStore;
		logic [decodePkg::memSizeWidth-1:0] memSize;
		logic                               isBranch;
		logic                               isDecBranch;
		logic [decodePkg::condWidth-1:0]    cond;
		logic [decodePkg::regIdxWidth-1:0]  rd;
		logic [decodePkg::regIdxWidth-1:0]  rs1;
		logic [decodePkg::regIdxWidth-1:0]  rs2;
		logic                               writesRd;
		logic [immWidth-1:0]                imm;
	} record_t;

	// Expected records in the order the instructions are offered
	record_t expected [$];

	int mismatches = 0;
	int extras = 0;
	int seen = 0;

	assign mismatchCount = mismatches;
	assign extraCount    = extras;
	assign seenCount     = seen;

	// Queue one expected record while the testbench reads the file
	task automatic addExpected(
		input logic [decodePkg::unitWidth-1:0]    u,
		input logic                               alu,
		input logic                               load,
		input logic                               store,
		input logic [decodePkg::memSizeWidth-1:0] size,
		input logic                               branch,
		input logic                               decBranch,
		input logic [decodePkg::condWidth-1:0]    cc,
		input logic [decodePkg::regIdxWidth-1:0]  d,
		input logic [decodePkg::regIdxWidth-1:0]  s1,
		input logic [decodePkg::regIdxWidth-1:0]  s2,
		input logic                               writes,
		input logic [immWidth-1:0]                immValue
	);
		expected.push_back({u, alu, load, store, size, branch, decBranch, cc, d, s1, s2,
			writes, immValue});
	endtask

	task automatic compareField(input string name, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want)
		begin
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
			mismatches++;
		end
	endtask

	// =========================================================================
	// Output handshake monitor
	// =========================================================================

	// Values sampled at the edge are the ones held through the cycle before it
	always @(posedge clk)
	begin
		record_t want;
		if (rstN && outValid && outReady)
		begin
			if (expected.size() == 0)
			begin
				$display("At %0t ns a record came out with no instruction left to match it",
					$time);
				extras++;
			end
			else
			begin
				want = expected.pop_front();
				seen++;
				compareField("unit", 64'(unit), 64'(want.unit));
				compareField("isAlu", 64'(isAlu), 64'(want.isAlu));
				compareField("isLoad", 64'(isLoad), 64'(want.isLoad));
				compareField("isStore", 64'(isStore), 64'(want.isStore));
				compareField("memSize", 64'(memSize), 64'(want.memSize));
				compareField("isBranch", 64'(isBranch), 64'(want.isBranch));
				compareField("isDecBranch", 64'(isDecBranch), 64'(want.isDecBranch));
				compareField("cond", 64'(cond), 64'(want.cond));
				compareField("rd", 64'(rd), 64'(want.rd));
				compareField("rs1", 64'(rs1), 64'(want.rs1));
				compareField("rs2", 64'(rs2), 64'(want.rs2));
				compareField("writesRd", 64'(writesRd), 64'(want.writesRd));
				compareField("imm", 64'(imm), 64'(want.imm));
			end
		end
	end

endmodule

// File: verif/decodeStage_sva.sv
// Decode stage handshake assertions
`timescale 1ns/1ns

module decodeStage_sva
#(
	parameter int immWidth = 32
)
(
	input logic                               clk,
	input logic                               rstN,
	input logic                               instrReady,
	input logic                               outValid,
	input logic                               outReady,
	input logic [decodePkg::unitWidth-1:0]    unit,
	input logic                               isAlu,
	input logic                               isLoad,
	input logic                               isStore,
	input logic [decodePkg::memSizeWidth-1:0] memSize,
	input logic                               isBranch,
	input logic                               isDecBranch,
	input logic [decodePkg::condWidth-1:0]    cond,
	input logic [decodePkg::regIdxWidth-1:0]  rd,
	input logic [decodePkg::regIdxWidth-1:0]  rs1,
	input logic [decodePkg::regIdxWidth-1:0]  rs2,
	input logic                               writesRd,
	input logic [immWidth-1:0]                imm
);

	// Whole decoded record as one vector so a single check covers every field
	logic [immWidth+28:0] record;

	assign record = {unit, isAlu, isLoad, isStore, memSize, isBranch, isDecBranch,
		cond, rd, rs1, rs2, writesRd, imm};

	// =========================================================================
	// Reset and handshake rules
	// =========================================================================

	// The register is empty right after a reset edge
	resetClearsValid: assert property (@(posedge clk) !rstN |=> !outValid)
		else $error("outValid still high after a reset edge");

	// A record that is not taken stays put until the downstream accepts it
	heldRecordStable: assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(record))
		else $error("Decoded record changed or vanished while stalled");

	// An empty register always has room for a new word
	readyWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
		!outValid |-> instrReady)
		else $error("instrReady low while the output register is empty");

endmodule

bind decodeStage decodeStage_sva #(.immWidth(immWidth)) sva_i
(
	.clk         (clk),
	.rstN        (rstN),
	.instrReady  (instrReady),
	.outValid    (outValid),
	.outReady    (outReady),
	.unit        (unit),
	.isAlu       (isAlu),
	.isLoad      (isLoad),
	.isStore     (isStore),
	.memSize     (memSize),
	.isBranch    (isBranch),
	.isDecBranch (isDecBranch),
	.cond        (cond),
	.rd          (rd),
	.rs1         (rs1),
	.rs2         (rs2),
	.writesRd    (writesRd),
	.imm         (imm)
);

// File: rtl/decodeStage.sv
// Instruction decode stage
`timescale 1ns/1ns

module decodeStage
#(
	parameter int immWidth = 32
)
(
	input  logic                              clk,
	input  logic                              rstN,
	input  logic                              instrValid,
	output logic                              instrReady,
	input  logic [isaPkg::instrWidth-1:0]     instr,
	input  logic                              outReady,
	output logic                              outValid,
	output decodePkg::unit_t                  unit,
	output logic                              isAlu,
	output logic                              isLoad,
	output logic                              isStore,
	output decodePkg::memSize_t               memSize,
	output logic                              isBranch,
	output logic                              isDecBranch,
	output logic [decodePkg::condWidth-1:0]   cond,
	output logic [decodePkg::regIdxWidth-1:0] rd,
	output logic [decodePkg::regIdxWidth-1:0] rs1,
	output logic [decodePkg::regIdxWidth-1:0] rs2,
	output logic                              writesRd,
	output logic [immWidth-1:0]               imm
);

	// Combinational results for the word now on the input port
	decodePkg::unit_t                  decUnit;
	logic                              decIsAlu;
	logic                              decIsLoad;
	logic                              decIsStore;
	decodePkg::memSize_t               decMemSize;
	logic                              decIsBranch;
	logic                              decIsDecBranch;
	logic [decodePkg::condWidth-1:0]   decCond;
	logic [decodePkg::regIdxWidth-1:0] decRd;
	logic [decodePkg::regIdxWidth-1:0] decRs1;
	logic [decodePkg::regIdxWidth-1:0] decRs2;
	logic                              decWritesRd;
	logic [immWidth-1:0]               decImm;

	// High on an edge where the input word is taken
	logic accept;

	// =========================================================================
	// Classifiers
	// =========================================================================

	decodeAlu uAlu
	(
		.instr (instr),
		.isAlu (decIsAlu)
	);

	decodeMem uMem
	(
		.instr   (instr),
		.isLoad  (decIsLoad),
		.isStore (decIsStore),
		.memSize (decMemSize)
	);

	decodeBranch uBranch
	(
		.instr       (instr),
		.isBranch    (decIsBranch),
		.isDecBranch (decIsDecBranch),
		.cond        (decCond)
	);

	decodeOperands #(.immWidth(immWidth)) uOperands
	(
		.instr    (instr),
		.rd       (decRd),
		.rs1      (decRs1),
		.rs2      (decRs2),
		.writesRd (decWritesRd),
		.imm      (decImm)
	);

	// The ALU claim wins so DBcc and the cheap floating forms stay off the FPU
	always_comb
	begin
		if (decIsAlu)
			decUnit = decodePkg::unitAlu;
		else if (isaPkg::fnOpcode(instr) == isaPkg::OP_FLT)
			decUnit = decodePkg::unitFpu;
		else if (decIsLoad || decIsStore)
			decUnit = decodePkg::unitMem;
		else if (decIsBranch)
			decUnit = decodePkg::unitBranch;
		else
			decUnit = decodePkg::unitIllegal;
	end

	// =========================================================================
	// Output register
	// =========================================================================

	// Space opens when the register is empty or its content leaves this cycle
	assign instrReady = !outValid || outReady;
	assign accept     = instrValid && instrReady;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else if (instrReady)
			outValid <= instrValid;
	end

	// The record only changes on acceptance so it holds still under a stall
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			unit        <= decUnit;
			isAlu       <= decIsAlu;
			isLoad      <= decIsLoad;
			isStore     <= decIsStore;
			memSize     <= decMemSize;
			isBranch    <= decIsBranch;
			isDecBranch <= decIsDecBranch;
			cond        <= decCond;
			rd          <= decRd;
			rs1         <= decRs1;
			rs2         <= decRs2;
			writesRd    <= decWritesRd;
			imm         <= decImm;
		end
	end

endmodule

// File: rtl/decodeOperands.sv
// Operand field decoder
`timescale 1ns/1ns

module decodeOperands
#(
	parameter int immWidth = 32
)
(
	input  logic [isaPkg::instrWidth-1:0]    instr,
	output logic [decodePkg::regIdxWidth-1:0] rd,
	output logic [decodePkg::regIdxWidth-1:0] rs1,
	output logic [decodePkg::regIdxWidth-1:0] rs2,
	output logic                              writesRd,
	output logic [immWidth-1:0]               imm
);

	// Width of the raw immediate field in the word
	localparam int immFieldWidth = isaPkg::immMsb - isaPkg::immLsb + 1;

	isaPkg::opcode_t           opcode;
	logic [immFieldWidth-1:0]  immField;

	assign opcode = isaPkg::fnOpcode(instr);

	// =========================================================================
	// Register numbers and immediate
	// =========================================================================

	// Register fields are always extracted even if a form leaves some unused
	assign rd  = instr[isaPkg::rdMsb:isaPkg::rdLsb];
	assign rs1 = instr[isaPkg::rs1Msb:isaPkg::rs1Lsb];
	assign rs2 = instr[isaPkg::rs2Msb:isaPkg::rs2Lsb];

	// Immediate bit 31 is the sign and it is carried up to the full width
	assign immField = instr[isaPkg::immMsb:isaPkg::immLsb];
	assign imm      = immWidth'($signed(immField));

	// =========================================================================
	// Destination write
	// =========================================================================

	always_comb
	begin
		case (opcode)
			// Stores, plain branches and the no-result ops leave Rd alone
			isaPkg::OP_STORE, isaPkg::OP_BCC, isaPkg::OP_NOP, isaPkg::OP_FENCE:
				writesRd = 1'b0;
			// A compare into register 0 only sets flags
			isaPkg::OP_CMP:
				writesRd = (rd != '0);
			isaPkg::OP_ADD, isaPkg::OP_SUBF, isaPkg::OP_MUL, isaPkg::OP_DIV:
				writesRd = 1'b1;
			isaPkg::OP_AND, isaPkg::OP_OR, isaPkg::OP_XOR, isaPkg::OP_SHIFT:
				writesRd = 1'b1;
			isaPkg::OP_MOV, isaPkg::OP_LOADA, isaPkg::OP_CSR, isaPkg::OP_CHK:
				writesRd = 1'b1;
			// Push and pop update the stack pointer named in Rd
			isaPkg::OP_PUSH, isaPkg::OP_POP:
				writesRd = 1'b1;
			// DBcc writes back the decremented count
			isaPkg::OP_FLT, isaPkg::OP_LOAD, isaPkg::OP_DBCC:
				writesRd = 1'b1;
			// Illegal opcodes must not disturb the register file
			default:
				writesRd = 1'b0;
		endcase
	end

endmodule

// File: rtl/decodeBranch.sv
// Branch decoder
`timescale 1ns/1ns

module decodeBranch
(
	input  logic [isaPkg::instrWidth-1:0]  instr,
	output logic                           isBranch,
	output logic                           isDecBranch,
	output logic [decodePkg::condWidth-1:0] cond
);

	isaPkg::opcode_t opcode;

	// Set for the counting branch only
	logic dbcc;

	assign opcode = isaPkg::fnOpcode(instr);
	assign dbcc   = isaPkg::fnIsDBcc(opcode);

	// =========================================================================
	// Branch flags
	// =========================================================================

	// Both branch forms redirect the fetch stream
	// DBcc also decrements a register, which the ALU class picks up
	assign isBranch    = (opcode == isaPkg::OP_BCC) || dbcc;
	assign isDecBranch = dbcc;

	// =========================================================================
	// Condition
	// =========================================================================

	// Condition code sits in the top three bits of the word
	// It is passed on for every instruction and read only for branches
	assign cond = instr[isaPkg::topMsb:isaPkg::topLsb];

endmodule

// File: rtl/decodeMem.sv
// Memory access decoder
`timescale 1ns/1ns

module decodeMem
(
	input  logic [isaPkg::instrWidth-1:0] instr,
	output logic                          isLoad,
	output logic                          isStore,
	output decodePkg::memSize_t           memSize
);

	isaPkg::opcode_t opcode;

	// Loads and stores reuse the low bits of the Rs2 slot as a size code
	logic [decodePkg::memSizeWidth-1:0] sizeCode;

	assign opcode   = isaPkg::fnOpcode(instr);
	assign sizeCode = instr[isaPkg::rs2Lsb +: decodePkg::memSizeWidth];

	// =========================================================================
	// Access kind
	// =========================================================================

	// Each direction has its own major opcode
	assign isLoad  = (opcode == isaPkg::OP_LOAD);
	assign isStore = (opcode == isaPkg::OP_STORE);

	// =========================================================================
	// Access width
	// =========================================================================

	// The size is extracted for every word and only means something for memory ops
	// The reserved code folds onto a word access
	always_comb
	begin
		case (sizeCode)
			2'd0:
				memSize = decodePkg::memByte;
			2'd1:
				memSize = decodePkg::memHalf;
			default:
				memSize = decodePkg::memWord;
		endcase
	end

endmodule

// File: rtl/decodeAlu.sv
// Integer ALU class decoder
`timescale 1ns/1ns

module decodeAlu
(
	input  logic [isaPkg::instrWidth-1:0] instr,
	output logic                          isAlu
);

	// Opcode and floating selector of the incoming word
	isaPkg::opcode_t opcode;
	isaPkg::fop4_t   fop4;

	// Format modifier and second source pick out the absolute-value form
	logic [isaPkg::topMsb-isaPkg::topLsb:0] topField;
	logic [isaPkg::rs2Msb-isaPkg::rs2Lsb:0] rs2Field;

	assign opcode   = isaPkg::fnOpcode(instr);
	assign fop4     = isaPkg::fop4_t'(instr[isaPkg::fop4Msb:isaPkg::fop4Lsb]);
	assign topField = instr[isaPkg::topMsb:isaPkg::topLsb];
	assign rs2Field = instr[isaPkg::rs2Msb:isaPkg::rs2Lsb];

	// =========================================================================
	// Class decision
	// =========================================================================

	always_comb
	begin
		case (opcode)
			// Most floating work belongs to the FPU
			// A few forms only touch the sign bit or the exponent pattern
			isaPkg::OP_FLT:
				case (fop4)
					// Absolute value is an add with format 1 and Rs2 fixed at 1
					isaPkg::FOP4_ADD:
						isAlu = (topField == 3'b001) && (rs2Field == 5'd1);
					isaPkg::FOP4_G8:
						isAlu = 1'b1;
					default:
						isAlu = 1'b0;
				endcase
			// Plain integer arithmetic and logic
			isaPkg::OP_ADD, isaPkg::OP_SUBF, isaPkg::OP_CMP,
			isaPkg::OP_MUL, isaPkg::OP_DIV:
				isAlu = 1'b1;
			isaPkg::OP_AND, isaPkg::OP_OR, isaPkg::OP_XOR, isaPkg::OP_SHIFT:
				isAlu = 1'b1;
			// Moves, address loads, CSR access and bounds checks
			isaPkg::OP_MOV, isaPkg::OP_LOADA, isaPkg::OP_CSR, isaPkg::OP_CHK:
				isAlu = 1'b1;
			// These have no real ALU work but still pass through its slot
			isaPkg::OP_NOP, isaPkg::OP_FENCE, isaPkg::OP_PUSH, isaPkg::OP_POP:
				isAlu = 1'b1;
			// Only DBcc remains among the other opcodes
			default:
				isAlu = isaPkg::fnIsDBcc(opcode);
		endcase
	end

endmodule

// File: rtl/decodePkg.sv
// Decoded record definitions
package decodePkg;

	// =========================================================================
	// Field widths of the decoded record
	// =========================================================================

	// Register numbers address a file of 32 registers
	localparam int regIdxWidth = 5;

	// Branch condition copied from the top field
	localparam int condWidth = 3;

	// Encoded widths of the two enumerations below
	localparam int memSizeWidth = 2;
	localparam int unitWidth = 3;

	// =========================================================================
	// Execution unit and access size
	// =========================================================================

	// Unit that will execute the instruction
	// DBcc lands on the ALU since the count-down is done there
	typedef enum logic [unitWidth-1:0] {
		unitAlu     = 3'd0,
		unitFpu     = 3'd1,
		unitMem     = 3'd2,
		unitBranch  = 3'd3,
		unitIllegal = 3'd4
	} unit_t;

	// Access width of a load or store
	// Size code 3 is reserved and is read as a word access
	typedef enum logic [memSizeWidth-1:0] {
		memByte = 2'd0,
		memHalf = 2'd1,
		memWord = 2'd2
	} memSize_t;

endpackage

// File: rtl/isaPkg.sv
// Instruction set definitions
package isaPkg;

	// =========================================================================
	// Instruction word geometry
	// =========================================================================

	// Every instruction is a single 32-bit word
	localparam int instrWidth = 32;
	localparam int opcodeWidth = 7;
	localparam int fop4Width = 4;

	// Major opcode occupies the low seven bits
	localparam int opLsb = 0;

	// Destination and source register numbers
	localparam int rdMsb = 11;
	localparam int rdLsb = 7;
	localparam int rs1Msb = 16;
	localparam int rs1Lsb = 12;
	localparam int rs2Msb = 21;
	localparam int rs2Lsb = 17;

	// Floating sub-operation selector overlaps the upper immediate bits
	localparam int fop4Msb = 25;
	localparam int fop4Lsb = 22;

	// The top field carries a branch condition or a floating format modifier
	localparam int topMsb = 31;
	localparam int topLsb = 29;

	// Immediate is fifteen bits and shares its low end with Rs2
	localparam int immMsb = 31;
	localparam int immLsb = 17;

	// =========================================================================
	// Opcodes
	// =========================================================================

	// Codes not listed here are illegal
	typedef enum logic [opcodeWidth-1:0] {
		OP_ADD   = 7'h04,
		OP_SUBF  = 7'h05,
		OP_CMP   = 7'h06,
		OP_MUL   = 7'h07,
		OP_DIV   = 7'h08,
		OP_AND   = 7'h09,
		OP_OR    = 7'h0A,
		OP_XOR   = 7'h0B,
		OP_SHIFT = 7'h0C,
		OP_MOV   = 7'h0D,
		OP_LOADA = 7'h0E,
		OP_CSR   = 7'h0F,
		OP_CHK   = 7'h10,
		OP_NOP   = 7'h11,
		OP_FENCE = 7'h12,
		OP_PUSH  = 7'h13,
		OP_POP   = 7'h14,
		OP_FLT   = 7'h20,
		OP_LOAD  = 7'h30,
		OP_STORE = 7'h31,
		OP_BCC   = 7'h40,
		OP_DBCC  = 7'h41
	} opcode_t;

	// Floating sub-operations in bits 25 to 22
	// The G8 group holds sign moves and class tests done on the integer ALU
	typedef enum logic [fop4Width-1:0] {
		FOP4_ADD  = 4'd0,
		FOP4_SUB  = 4'd1,
		FOP4_MUL  = 4'd2,
		FOP4_DIV  = 4'd3,
		FOP4_SQRT = 4'd4,
		FOP4_CVT  = 4'd5,
		FOP4_CMP  = 4'd6,
		FOP4_G8   = 4'd8
	} fop4_t;

	// Pull the major opcode out of an instruction word
	function automatic opcode_t fnOpcode(input logic [instrWidth-1:0] ir);
		return opcode_t'(ir[opLsb +: opcodeWidth]);
	endfunction

	// Decrement-and-branch counts down a register through the ALU
	function automatic logic fnIsDBcc(input opcode_t op);
		return op == OP_DBCC;
	endfunction

endpackage
